// ==== Bender.yml ====
package:
  name: commit_core

sources:
  - design/commit_pkg.sv
  - design/retire_if.sv
  - design/pipe_reg.sv
  - design/rob_buffer.sv
  - design/retire_writeback.sv
  - design/arch_regfile.sv
  - design/commit_core.sv
  - target: simulation
    files:
      - verif/commit_core_checker.sv
      - verif/commit_core_tb.sv

// ==== design/arch_regfile.sv ====
// architectural register file
`timescale 1ns/1ps

module arch_regfile (
	input  logic                        clk,
	input  logic                        reset,
	input  commit_pkg::commit_packet_t  commit,
	input  commit_pkg::reg_idx_t        rd_idx,
	output commit_pkg::word_t           rd_data
);

	commit_pkg::word_t regs [commit_pkg::NUM_ARCH_REGS];

	// three write ports from the commit register
	// duplicates already resolved upstream
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int r = 0; r < commit_pkg::NUM_ARCH_REGS; r++) begin
				regs[r] <= '0;
			end
		end else begin
			for (int i = 0; i < commit_pkg::WIDTH; i++) begin
				if (commit.wr_en[i] && (commit.wr_idx[i] != commit_pkg::ZERO_REG)) begin
					regs[commit.wr_idx[i]] <= commit.wr_data[i];
				end
			end
		end
	end

	// async read, x0 forced to zero
	assign rd_data = (rd_idx == commit_pkg::ZERO_REG) ? '0 : regs[rd_idx];

endmodule

// ==== design/commit_core.sv ====
// commit path top level
`timescale 1ns/1ps

module commit_core (
	input  logic                                         clk,
	input  logic                                         reset,
	// dispatch group, slot 0 oldest
	input  logic [commit_pkg::WIDTH-1:0]                 dispatch_valid,
	input  commit_pkg::reg_idx_t [commit_pkg::WIDTH-1:0] dispatch_dest,
	input  logic [commit_pkg::WIDTH-1:0]                 dispatch_halt,
	output commit_pkg::rob_tag_t                         tag_base,
	output logic                                         dispatch_ready,
	// completion, no back-pressure
	input  logic [commit_pkg::WIDTH-1:0]                 cdb_valid,
	input  commit_pkg::rob_tag_t [commit_pkg::WIDTH-1:0] cdb_tag,
	input  commit_pkg::word_t [commit_pkg::WIDTH-1:0]    cdb_value,
	// commit group
	output logic [commit_pkg::WIDTH-1:0]                 commit_wr_en,
	output commit_pkg::reg_idx_t [commit_pkg::WIDTH-1:0] commit_wr_idx,
	output commit_pkg::word_t [commit_pkg::WIDTH-1:0]    commit_wr_data,
	output logic [1:0]                                   completed_insts,
	output commit_pkg::commit_status_t                   status,
	// register read port
	input  commit_pkg::reg_idx_t                         rd_idx,
	output commit_pkg::word_t                            rd_data
);

	commit_pkg::cdb_packet_t cdb_in;
	commit_pkg::cdb_packet_t cdb_q;
	commit_pkg::commit_packet_t commit_d;
	commit_pkg::commit_packet_t commit_q;
	logic halted;

	////////////////////////////////////////
	// completion bus register
	////////////////////////////////////////

	// pack loose ports into the bus struct
	assign cdb_in.valid = cdb_valid;
	assign cdb_in.tag = cdb_tag;
	assign cdb_in.value = cdb_value;

	// one cycle before the buffer sees it
	pipe_reg #(
		.payload_t(commit_pkg::cdb_packet_t)
	) cdb_reg (
		.clk(clk),
		.reset(reset),
		.d(cdb_in),
		.q(cdb_q)
	);

	////////////////////////////////////////
	// reorder buffer and retire
	////////////////////////////////////////

	retire_if retire_bus ();

	rob_buffer rob (
		.clk(clk),
		.reset(reset),
		.dispatch_valid(dispatch_valid),
		.dispatch_dest(dispatch_dest),
		.dispatch_halt(dispatch_halt),
		.cdb(cdb_q),
		.tag_base(tag_base),
		.dispatch_ready(dispatch_ready),
		.retire(retire_bus.rob),
		.halted(halted)
	);

	retire_writeback writeback (
		.retire(retire_bus.wb),
		.commit(commit_d)
	);

	// loads at the retiring edge
	pipe_reg #(
		.payload_t(commit_pkg::commit_packet_t)
	) commit_reg (
		.clk(clk),
		.reset(reset),
		.d(commit_d),
		.q(commit_q)
	);

	////////////////////////////////////////
	// register file and outputs
	////////////////////////////////////////

	// written one edge after the commit register
	arch_regfile regfile (
		.clk(clk),
		.reset(reset),
		.commit(commit_q),
		.rd_idx(rd_idx),
		.rd_data(rd_data)
	);

	assign commit_wr_en = commit_q.wr_en;
	assign commit_wr_idx = commit_q.wr_idx;
	assign commit_wr_data = commit_q.wr_data;
	assign completed_insts = commit_q.count;
	// halted sets on the same edge that loads the halt commit
	assign status = halted ? commit_pkg::STATUS_HALTED : commit_pkg::STATUS_OK;

endmodule

// ==== design/commit_pkg.sv ====
// commit path definitions

package commit_pkg;

	////////////////////////////////////////
	// sizes
	////////////////////////////////////////

	// slots per dispatch, completion and retire group
	localparam int WIDTH = 3;
	// data word width
	localparam int XLEN = 32;
	// architectural register file
	localparam int NUM_ARCH_REGS = 32;
	localparam int REG_IDX_W = 5;
	// reorder buffer depth, power of two so tags wrap
	localparam int ROB_SIZE = 16;
	localparam int ROB_TAG_W = 4;

	////////////////////////////////////////
	// basic types
	////////////////////////////////////////

	typedef logic [ROB_TAG_W-1:0] rob_tag_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;
	typedef logic [XLEN-1:0] word_t;

	// x0 is hardwired, never written
	localparam reg_idx_t ZERO_REG = '0;

	////////////////////////////////////////
	// packets
	////////////////////////////////////////

	// completion bus, one entry per slot
	typedef struct packed {
		logic [WIDTH-1:0] valid;
		rob_tag_t [WIDTH-1:0] tag;
		word_t [WIDTH-1:0] value;
	} cdb_packet_t;

	// registered commit group
	// count is valid slots, not enabled writes
	typedef struct packed {
		logic [WIDTH-1:0] wr_en;
		reg_idx_t [WIDTH-1:0] wr_idx;
		word_t [WIDTH-1:0] wr_data;
		logic [1:0] count;
	} commit_packet_t;

	// sticky halt state seen at the top
	typedef enum logic [1:0] {
		STATUS_OK = 2'd0,
		STATUS_HALTED = 2'd1
	} commit_status_t;

endpackage

// ==== design/pipe_reg.sv ====
// generic pipeline register
`timescale 1ns/1ps

module pipe_reg #(
	// payload carried across the edge
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     reset,
	input  payload_t d,
	output payload_t q
);

	// loads every cycle, no enable
	// reset zeroes the whole payload so valid bits drop
	always_ff @(posedge clk) begin
		if (reset) begin
			q <= '0;
		end else begin
			q <= d;
		end
	end

endmodule

// ==== design/retire_if.sv ====
// retire group bus
`timescale 1ns/1ps

interface retire_if;

	// slot 0 oldest, valid contiguous from slot 0
	logic [commit_pkg::WIDTH-1:0] retire_valid;
	// destination register per slot
	commit_pkg::reg_idx_t [commit_pkg::WIDTH-1:0] retire_dest;
	// completed result per slot
	commit_pkg::word_t [commit_pkg::WIDTH-1:0] retire_value;

	// buffer side drives the group
	modport rob (
		output retire_valid,
		output retire_dest,
		output retire_value
	);

	// writeback side, group taken in the cycle it shows
	modport wb (
		input retire_valid,
		input retire_dest,
		input retire_value
	);

endinterface

// ==== design/retire_writeback.sv ====
// retire group write enables
`timescale 1ns/1ps

module retire_writeback (
	retire_if.wb                        retire,
	output commit_pkg::commit_packet_t  commit
);

	// purely combinational, registered outside
	always_comb begin
		logic younger_hit;
		logic [1:0] valid_cnt;
		valid_cnt = '0;
		for (int i = 0; i < commit_pkg::WIDTH; i++) begin
			// any younger valid slot with same dest wins
			younger_hit = 1'b0;
			for (int j = i + 1; j < commit_pkg::WIDTH; j++) begin
				if (retire.retire_valid[j] &&
				    (retire.retire_dest[j] == retire.retire_dest[i])) begin
					younger_hit = 1'b1;
				end
			end
			// no write to x0, older duplicate suppressed
			commit.wr_en[i] = retire.retire_valid[i] &&
			                  (retire.retire_dest[i] != commit_pkg::ZERO_REG) &&
			                  !younger_hit;
			// index and data pass straight through
			commit.wr_idx[i] = retire.retire_dest[i];
			commit.wr_data[i] = retire.retire_value[i];
			// every retired slot counts, enabled or not
			if (retire.retire_valid[i]) begin
				valid_cnt = valid_cnt + 2'd1;
			end
		end
		commit.count = valid_cnt;
	end

endmodule

// ==== design/rob_buffer.sv ====
// reorder buffer
`timescale 1ns/1ps

module rob_buffer (
	input  logic                                         clk,
	input  logic                                         reset,
	input  logic [commit_pkg::WIDTH-1:0]                 dispatch_valid,
	input  commit_pkg::reg_idx_t [commit_pkg::WIDTH-1:0] dispatch_dest,
	input  logic [commit_pkg::WIDTH-1:0]                 dispatch_halt,
	input  commit_pkg::cdb_packet_t                      cdb,
	output commit_pkg::rob_tag_t                         tag_base,
	output logic                                         dispatch_ready,
	retire_if.rob                                        retire,
	output logic                                         halted
);

	////////////////////////////////////////
	// state
	////////////////////////////////////////

	// circular pointers, wrap through tag width
	commit_pkg::rob_tag_t head;
	commit_pkg::rob_tag_t tail;
	// occupancy 0..ROB_SIZE needs one extra bit
	logic [commit_pkg::ROB_TAG_W:0] count;

	// per-entry fields
	commit_pkg::reg_idx_t entry_dest [commit_pkg::ROB_SIZE];
	commit_pkg::word_t entry_value [commit_pkg::ROB_SIZE];
	logic [commit_pkg::ROB_SIZE-1:0] entry_done;
	logic [commit_pkg::ROB_SIZE-1:0] entry_halt;

	// dispatch side
	logic [commit_pkg::WIDTH-1:0] disp_take;
	commit_pkg::rob_tag_t [commit_pkg::WIDTH-1:0] disp_idx;
	logic [1:0] disp_num;

	// retire side
	commit_pkg::rob_tag_t [commit_pkg::WIDTH-1:0] ret_idx;
	logic [1:0] ret_num;
	logic ret_halt;

	////////////////////////////////////////
	// dispatch
	////////////////////////////////////////

	// room for a full group
	assign dispatch_ready = (count <= (commit_pkg::ROB_SIZE - commit_pkg::WIDTH));
	// group ignored while not ready
	assign disp_take = dispatch_valid & {commit_pkg::WIDTH{dispatch_ready}};
	// slot 0 tag, slot i gets tail+i
	assign tag_base = tail;

	always_comb begin
		disp_num = '0;
		for (int i = 0; i < commit_pkg::WIDTH; i++) begin
			disp_idx[i] = tail + commit_pkg::rob_tag_t'(i);
			if (disp_take[i]) begin
				disp_num = disp_num + 2'd1;
			end
		end
	end

	////////////////////////////////////////
	// retire group
	////////////////////////////////////////

	// consecutive done entries from head
	// stops at first not-done, after a halt, or once halted
	always_comb begin
		logic stop;
		stop = halted;
		ret_num = '0;
		ret_halt = 1'b0;
		for (int i = 0; i < commit_pkg::WIDTH; i++) begin
			ret_idx[i] = head + commit_pkg::rob_tag_t'(i);
			retire.retire_valid[i] = 1'b0;
			retire.retire_dest[i] = entry_dest[ret_idx[i]];
			retire.retire_value[i] = entry_value[ret_idx[i]];
			if (!stop && (count > i) && entry_done[ret_idx[i]]) begin
				retire.retire_valid[i] = 1'b1;
				ret_num = ret_num + 2'd1;
				// halt retires itself, younger ones wait forever
				if (entry_halt[ret_idx[i]]) begin
					ret_halt = 1'b1;
					stop = 1'b1;
				end
			end else begin
				stop = 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// control update
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			halted <= 1'b0;
			entry_done <= '0;
		end else begin
			head <= head + commit_pkg::rob_tag_t'(ret_num);
			tail <= tail + commit_pkg::rob_tag_t'(disp_num);
			count <= count + disp_num - ret_num;
			// sticky until reset
			if (ret_halt) begin
				halted <= 1'b1;
			end
			// new entries start not done
			for (int i = 0; i < commit_pkg::WIDTH; i++) begin
				if (disp_take[i]) begin
					entry_done[disp_idx[i]] <= 1'b0;
				end
			end
			// registered cdb marks entries done
			for (int i = 0; i < commit_pkg::WIDTH; i++) begin
				if (cdb.valid[i]) begin
					entry_done[cdb.tag[i]] <= 1'b1;
				end
			end
		end
	end

	// entry payload
	always_ff @(posedge clk) begin
		for (int i = 0; i < commit_pkg::WIDTH; i++) begin
			if (disp_take[i]) begin
				entry_dest[disp_idx[i]] <= dispatch_dest[i];
				entry_halt[disp_idx[i]] <= dispatch_halt[i];
			end
		end
		for (int i = 0; i < commit_pkg::WIDTH; i++) begin
			if (cdb.valid[i]) begin
				entry_value[cdb.tag[i]] <= cdb.value[i];
			end
		end
	end

endmodule

// ==== verif/commit_core_checker.sv ====
// commit path assertions
`timescale 1ns/1ps

module commit_core_checker (
	input logic                                         clk,
	input logic                                         reset,
	input logic [commit_pkg::WIDTH-1:0]                 dispatch_valid,
	input commit_pkg::rob_tag_t                         tag_base,
	input logic [commit_pkg::WIDTH-1:0]                 commit_wr_en,
	input commit_pkg::reg_idx_t [commit_pkg::WIDTH-1:0] commit_wr_idx,
	input commit_pkg::commit_status_t                   status
);

	// slots whose index is x0
	logic [commit_pkg::WIDTH-1:0] zero_slot;

	always_comb begin
		for (int i = 0; i < commit_pkg::WIDTH; i++) begin
			zero_slot[i] = (commit_wr_idx[i] == commit_pkg::ZERO_REG);
		end
	end

	// x0 is never a write target
	assert property (@(posedge clk) disable iff (reset) (commit_wr_en & zero_slot) == '0)
		else $error("commit write enabled at register zero");

	// halt is sticky until reset
	assert property (@(posedge clk) disable iff (reset)
		status == commit_pkg::STATUS_HALTED |=> status == commit_pkg::STATUS_HALTED)
		else $error("status left halted without reset");

	// tail only moves on a dispatch
	assert property (@(posedge clk) disable iff (reset) dispatch_valid == '0 |=> $stable(tag_base))
		else $error("tag_base moved with no dispatch");

endmodule

bind commit_core commit_core_checker checker_inst (.*);

// ==== verif/commit_core_tb.sv ====
// commit path testbench
`timescale 1ns/1ps

module commit_core_tb;

	localparam int W = commit_pkg::WIDTH;
	// rough cycle sum of all tests
	localparam int TEST_CYCLES = 200;
	localparam int DRAIN_LIMIT = 100;

	logic clk;
	logic reset;
	logic [W-1:0] dispatch_valid;
	commit_pkg::reg_idx_t [W-1:0] dispatch_dest;
	logic [W-1:0] dispatch_halt;
	commit_pkg::rob_tag_t tag_base;
	logic dispatch_ready;
	logic [W-1:0] cdb_valid;
	commit_pkg::rob_tag_t [W-1:0] cdb_tag;
	commit_pkg::word_t [W-1:0] cdb_value;
	logic [W-1:0] commit_wr_en;
	commit_pkg::reg_idx_t [W-1:0] commit_wr_idx;
	commit_pkg::word_t [W-1:0] commit_wr_data;
	logic [1:0] completed_insts;
	commit_pkg::commit_status_t status;
	commit_pkg::reg_idx_t rd_idx;
	commit_pkg::word_t rd_data;

	// current batch in dispatch order
	commit_pkg::rob_tag_t b_tag [$];
	commit_pkg::reg_idx_t b_dest [$];
	logic b_halt [$];
	commit_pkg::word_t b_value [$];
	// expected commit groups, oldest first
	logic [W-1:0] exp_en [$];
	commit_pkg::reg_idx_t [W-1:0] exp_idx [$];
	commit_pkg::word_t [W-1:0] exp_data [$];
	logic [1:0] exp_cnt [$];
	commit_pkg::commit_status_t exp_status [$];
	// architectural state as the model sees it
	commit_pkg::word_t model_regs [commit_pkg::NUM_ARCH_REGS];
	logic model_halted;
	// tail as the model sees it, one step per accepted slot
	commit_pkg::rob_tag_t model_tail;
	commit_pkg::reg_idx_t [W-1:0] dest_v;
	int error_count;
	int test_errors;
	int test_num;

	commit_core UUT (.*);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////

	task automatic check_word(input string name, input commit_pkg::word_t got, exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s: got %h expected %h", $time, name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_idx(input string name, input commit_pkg::reg_idx_t got, exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s: got %0d expected %0d", $time, name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_tag(input string name, input commit_pkg::rob_tag_t got, exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s: got %0d expected %0d", $time, name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_count(input string name, input logic [1:0] got, exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s: got %0d expected %0d", $time, name, got, exp);
			error_count++;
		end
	endtask

	// enable vectors
	task automatic check_bits(input string name, input logic [W-1:0] got, exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s: got %b expected %b", $time, name, got, exp);
			error_count++;
		end
	endtask

	// single flags
	task automatic check_flag(input string name, input logic got, exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s: got %b expected %b", $time, name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_status(input string name, input commit_pkg::commit_status_t got, exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s: got %0d expected %0d", $time, name, got, exp);
			error_count++;
		end
	endtask

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	// whole batch done before head, so groups are WIDTH-wide chunks from the head
	// chunk ends after a halt, nothing after it
	function automatic void ref_commit();
		int pos;
		int n;
		logic stop;
		logic [W-1:0] en;
		commit_pkg::reg_idx_t [W-1:0] idx;
		commit_pkg::word_t [W-1:0] data;
		pos = 0;
		while (pos < b_dest.size() && !model_halted) begin
			n = 0;
			stop = 1'b0;
			en = '0;
			idx = '0;
			data = '0;
			for (int i = 0; i < W; i++) begin
				if (!stop && (pos + i) < b_dest.size()) begin
					idx[i] = b_dest[pos+i];
					data[i] = b_value[pos+i];
					n++;
					stop = b_halt[pos+i];
					model_halted = model_halted | b_halt[pos+i];
				end else begin
					stop = 1'b1;
				end
			end
			// youngest duplicate wins, x0 never written
			for (int i = 0; i < n; i++) begin
				en[i] = (idx[i] != commit_pkg::ZERO_REG);
				for (int j = i + 1; j < n; j++) begin
					if (idx[j] == idx[i]) begin
						en[i] = 1'b0;
					end
				end
				if (en[i]) begin
					model_regs[idx[i]] = data[i];
				end
			end
			exp_en.push_back(en);
			exp_idx.push_back(idx);
			exp_data.push_back(data);
			exp_cnt.push_back(2'(n));
			exp_status.push_back(model_halted ? commit_pkg::STATUS_HALTED : commit_pkg::STATUS_OK);
			pos += n;
		end
	endfunction

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	task automatic start_batch();
		b_tag.delete();
		b_dest.delete();
		b_halt.delete();
		b_value.delete();
	endtask

	// tag read back once the previous group is in
	task automatic dispatch_group(input logic [W-1:0] valid, input logic [W-1:0] halt);
		@(posedge clk);
		dispatch_valid <= valid;
		dispatch_dest <= dest_v;
		dispatch_halt <= halt;
		@(negedge clk);
		check_tag("tag_base", tag_base, model_tail);
		for (int i = 0; i < W; i++) begin
			if (valid[i]) begin
				b_tag.push_back(tag_base + commit_pkg::rob_tag_t'(i));
				b_dest.push_back(dest_v[i]);
				b_halt.push_back(halt[i]);
				b_value.push_back($urandom);
				model_tail = model_tail + 1'b1;
			end
		end
	endtask

	task automatic random_dests();
		for (int i = 0; i < W; i++) begin
			dest_v[i] = $urandom_range(commit_pkg::NUM_ARCH_REGS - 1, 0);
		end
	endtask

	// shuffled completion, 1..WIDTH per cycle, oldest entry last
	task automatic complete_batch();
		int order [$];
		int j;
		int tmp;
		int k;
		int take;
		for (int i = 1; i < b_tag.size(); i++) begin
			order.push_back(i);
		end
		for (int i = order.size() - 1; i > 0; i--) begin
			j = $urandom_range(i, 0);
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		order.push_back(0);
		k = 0;
		while (k < order.size()) begin
			take = $urandom_range(W, 1);
			@(posedge clk);
			for (int s = 0; s < W; s++) begin
				cdb_valid[s] <= 1'b0;
				if (s < take && k < order.size()) begin
					cdb_valid[s] <= 1'b1;
					cdb_tag[s] <= b_tag[order[k]];
					cdb_value[s] <= b_value[order[k]];
					k++;
				end
			end
		end
		@(posedge clk);
		cdb_valid <= '0;
	endtask

	// wait for every expected group, then idle to catch stray commits
	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while (exp_cnt.size() != 0 && cycles < DRAIN_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		if (exp_cnt.size() != 0) begin
			$display("ERROR t=%0t: %0d commit groups never appeared", $time, exp_cnt.size());
			error_count++;
			exp_en.delete();
			exp_idx.delete();
			exp_data.delete();
			exp_cnt.delete();
			exp_status.delete();
		end
		repeat (6) @(posedge clk);
	endtask

	task automatic run_batch();
		@(posedge clk);
		dispatch_valid <= '0;
		ref_commit();
		complete_batch();
		wait_drain();
	endtask

	task automatic check_reads();
		for (int r = 0; r < commit_pkg::NUM_ARCH_REGS; r++) begin
			@(posedge clk);
			rd_idx <= commit_pkg::reg_idx_t'(r);
			@(negedge clk);
			check_word("rd_data", rd_data, model_regs[r]);
		end
	endtask

	task automatic end_test(input string name);
		test_num++;
		$display("test %0d %s: %s", test_num, name, (error_count == test_errors) ? "ok" : "errors");
		test_errors = error_count;
	endtask

	////////////////////////////////////////
	// compare process
	////////////////////////////////////////

	// outputs settle after the edge, sampled mid-cycle
	always @(negedge clk) begin : compare
		int n;
		if (!reset && (completed_insts != 2'd0 || commit_wr_en != '0)) begin
			if (exp_cnt.size() == 0) begin
				$display("ERROR t=%0t: commit group with nothing left to retire", $time);
				error_count++;
			end else begin
				n = exp_cnt[0];
				check_count("completed_insts", completed_insts, exp_cnt[0]);
				check_bits("commit_wr_en", commit_wr_en, exp_en[0]);
				check_status("status", status, exp_status[0]);
				for (int i = 0; i < n; i++) begin
					check_idx("commit_wr_idx", commit_wr_idx[i], exp_idx[0][i]);
					check_word("commit_wr_data", commit_wr_data[i], exp_data[0][i]);
				end
				void'(exp_en.pop_front());
				void'(exp_idx.pop_front());
				void'(exp_data.pop_front());
				void'(exp_cnt.pop_front());
				void'(exp_status.pop_front());
			end
		end
	end

	// bounded run time
	initial begin
		#(TEST_CYCLES * 4 * 10);
		$display("watchdog expired before the tests finished");
		$display("*** TEST FAILED ***");
		$finish;
	end

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial begin
		void'($urandom(12304));
		error_count = 0;
		test_errors = 0;
		test_num = 0;
		model_halted = 1'b0;
		model_tail = '0;
		foreach (model_regs[r]) begin
			model_regs[r] = '0;
		end
		reset = 1'b1;
		dispatch_valid = '0;
		dispatch_dest = '0;
		dispatch_halt = '0;
		cdb_valid = '0;
		cdb_tag = '0;
		cdb_value = '0;
		rd_idx = '0;
		dest_v = '0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		// reset state
		@(negedge clk);
		check_flag("dispatch_ready", dispatch_ready, 1'b1);
		check_bits("commit_wr_en", commit_wr_en, '0);
		check_count("completed_insts", completed_insts, 2'd0);
		check_status("status", status, commit_pkg::STATUS_OK);
		check_reads();
		end_test("reset state");

		// out-of-order completion, in-order commit
		start_batch();
		for (int g = 0; g < 4; g++) begin
			random_dests();
			dispatch_group('1, '0);
		end
		run_batch();
		end_test("random completion order");

		// dup dests and x0 inside one group, plus a partial group
		start_batch();
		dest_v = {5'd0, 5'd5, 5'd5};
		dispatch_group('1, '0);
		dest_v = {5'd7, 5'd0, 5'd7};
		dispatch_group('1, '0);
		dest_v = {5'd0, 5'd9, 5'd9};
		dispatch_group(3'b011, '0);
		run_batch();
		end_test("duplicate and zero destinations");

		check_reads();
		end_test("register read back");

		// fill to 15 entries, then offer one more group
		start_batch();
		for (int g = 0; g < 5; g++) begin
			random_dests();
			dispatch_group('1, '0);
		end
		@(posedge clk);
		dispatch_valid <= '1;
		@(negedge clk);
		check_flag("dispatch_ready", dispatch_ready, 1'b0);
		check_tag("tag_base", tag_base, model_tail);
		@(posedge clk);
		dispatch_valid <= '0;
		@(negedge clk);
		check_tag("tag_base", tag_base, model_tail);
		check_flag("dispatch_ready", dispatch_ready, 1'b0);
		run_batch();
		@(negedge clk);
		check_flag("dispatch_ready", dispatch_ready, 1'b1);
		end_test("full buffer back-pressure");

		// halt in slot 1, younger entries complete but stay
		start_batch();
		random_dests();
		dispatch_group('1, 3'b010);
		random_dests();
		dispatch_group('1, '0);
		run_batch();
		@(negedge clk);
		check_status("status", status, commit_pkg::STATUS_HALTED);
		end_test("halt stops retirement");

		$display("%0d tests run, %0d errors", test_num, error_count);
		if (error_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
design/commit_pkg.sv
design/retire_if.sv
design/pipe_reg.sv
design/rob_buffer.sv
design/retire_writeback.sv
design/arch_regfile.sv
design/commit_core.sv
verif/commit_core_checker.sv
verif/commit_core_tb.sv
